//--- design/board_defines.svh
/*
 * board subsystem timing and sizing constants
 * debounce hold time, digit scan rate, beep length and spi reply offset
 */
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// cycles a key level must hold before it is taken
`define DEBOUNCE_CYCLES 20

`define SCAN_CYCLES 8 // sys_clk cycles per lit digit
`define BEEP_CYCLES 40 // buzzer on time after a press

// added to the last received byte to form the reply
`define SPI_REPLY_OFFSET 8'd2

`define NUM_KEYS 4
`define NUM_DIGITS 8

`endif

//--- design/board_pkg.sv
/*
 * shared types for the board subsystem
 * display digits and frame, key events, spi receive strobe
 */
`default_nettype none

`include "board_defines.svh"

package board_pkg;

	// hex digit code, blanking is carried separately
	typedef enum logic [3:0] {
		DIG_0, DIG_1, DIG_2, DIG_3, DIG_4, DIG_5, DIG_6, DIG_7,
		DIG_8, DIG_9, DIG_A, DIG_B, DIG_C, DIG_D, DIG_E, DIG_F
	} digit_code_e;

	typedef struct packed {
		logic        blank; // 1 turns the digit off
		digit_code_e code;
	} seg_digit_t;

	// index 7 is the leftmost digit
	typedef seg_digit_t [`NUM_DIGITS-1:0] seg_frame_t;

	typedef struct packed {
		logic [`NUM_KEYS-1:0] level; // debounced, 1 = pressed
		logic [`NUM_KEYS-1:0] press; // single cycle on each new press
	} key_event_t;

	typedef struct packed {
		logic       done; // one cycle per complete byte
		logic [7:0] data;
	} spi_rx_t;

endpackage

`default_nettype wire

//--- design/key_debounce.sv
/*
 * key debouncer
 * syncs the active low keys, accepts a level after a stable hold,
 * emits press pulses and drives the leds
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module key_debounce import board_pkg::*; (
	input  wire logic                 sys_clk,
	input  wire logic                 sys_rst_n,
	input  wire logic [`NUM_KEYS-1:0] key_in,
	output key_event_t                keys,
	output logic      [7:0]           led
);

	localparam int DB_W = $clog2(`DEBOUNCE_CYCLES);

	logic [`NUM_KEYS-1:0] key_s1, key_s2; // pressed = 1 after inversion
	logic [DB_W-1:0]      db_cnt [`NUM_KEYS];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_s1     <= '0;
			key_s2     <= '0;
			keys.level <= '0;
			keys.press <= '0;
			for (int i = 0; i < `NUM_KEYS; i++) begin
				db_cnt[i] <= '0;
			end
		end else begin
			key_s1 <= ~key_in;
			key_s2 <= key_s1;
			for (int i = 0; i < `NUM_KEYS; i++) begin
				keys.press[i] <= 1'b0;
				if (key_s2[i] == keys.level[i]) begin
					db_cnt[i] <= '0; // input agrees, restart the hold
				end else if (db_cnt[i] == DB_W'(`DEBOUNCE_CYCLES - 1)) begin
					db_cnt[i]      <= '0;
					keys.level[i] <= key_s2[i];
					keys.press[i] <= key_s2[i]; // rising level only
				end else begin
					db_cnt[i] <= db_cnt[i] + 1'b1;
				end
			end
		end
	end

	// low nibble mirrors the held keys, high nibble toggles per press
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			led <= '0;
		end else begin
			led[3:0] <= keys.level;
			led[7:4] <= led[7:4] ^ keys.press;
		end
	end

	a_press_needs_level: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(keys.press & ~keys.level) == '0);

endmodule

`default_nettype wire

//--- design/spi_slave.sv
/*
 * spi slave, any cpol/cpha
 * oversamples sclk in the sys_clk domain, shifts msb first both ways,
 * pulses done after each complete byte
 */
`timescale 1ns/1ps
`default_nettype none

module spi_slave import board_pkg::*; #(
	parameter bit CPOL = 1'b1,
	parameter bit CPHA = 1'b1
) (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic       cs,
	input  wire logic       sclk,
	input  wire logic       mosi,
	output logic            miso,
	input  wire logic [7:0] data_tx,
	output spi_rx_t         rx
);

	// modes 0 and 3 sample on the rising edge
	localparam bit SAMPLE_ON_RISE = (CPOL == CPHA);

	logic [1:0] cs_sync, sclk_sync, mosi_sync;
	logic       cs_prev, sclk_prev;
	logic       cs_s, sclk_s, mosi_s;
	logic       sclk_rise, sclk_fall, cs_fall;
	logic       sample_edge, shift_edge;
	logic [3:0] bit_cnt;
	logic       sampled; // a bit was taken since cs fell
	logic       done_q;
	logic [7:0] tx_shift, rx_shift, rx_data;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cs_sync   <= 2'b11;
			sclk_sync <= {2{CPOL}};
			mosi_sync <= '0;
			cs_prev   <= 1'b1;
			sclk_prev <= CPOL;
		end else begin
			cs_sync   <= {cs_sync[0], cs};
			sclk_sync <= {sclk_sync[0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			cs_prev   <= cs_s;
			sclk_prev <= sclk_s;
		end
	end

	assign cs_s   = cs_sync[1];
	assign sclk_s = sclk_sync[1];
	assign mosi_s = mosi_sync[1];

	assign sclk_rise   = sclk_s & ~sclk_prev;
	assign sclk_fall   = ~sclk_s & sclk_prev;
	assign cs_fall     = ~cs_s & cs_prev;
	assign sample_edge = ~cs_s & (SAMPLE_ON_RISE ? sclk_rise : sclk_fall);
	assign shift_edge  = ~cs_s & (SAMPLE_ON_RISE ? sclk_fall : sclk_rise);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
			sampled <= 1'b0;
			done_q  <= 1'b0;
			miso    <= 1'b1;
		end else begin
			done_q <= sample_edge && (bit_cnt == 4'd7);
			if (cs_s) begin // idle or aborted transfer
				bit_cnt <= '0;
				sampled <= 1'b0;
				miso    <= 1'b1;
			end else if (cs_fall) begin
				bit_cnt <= '0;
				sampled <= 1'b0;
				miso    <= data_tx[7]; // first bit out before any clock
			end else begin
				if (sample_edge) begin
					sampled <= 1'b1;
					bit_cnt <= (bit_cnt == 4'd7) ? 4'd0 : bit_cnt + 4'd1;
				end
				if (shift_edge && sampled) begin
					miso <= tx_shift[6];
				end
			end
		end
	end

	// data path
	always_ff @(posedge sys_clk) begin
		if (cs_fall) begin
			tx_shift <= data_tx;
		end else if (shift_edge && sampled) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
		if (sample_edge) begin
			rx_shift <= {rx_shift[6:0], mosi_s};
		end
		if (sample_edge && bit_cnt == 4'd7) begin
			rx_data <= {rx_shift[6:0], mosi_s};
		end
	end

	assign rx.done = done_q;
	assign rx.data = rx_data;

	a_bit_cnt_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!cs_s |-> bit_cnt <= 4'd7);

	a_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx.done |=> !rx.done);

endmodule

`default_nettype wire

//--- design/display_format.sv
/*
 * display frame builder
 * spi byte in hex on the left, press count in decimal on the right
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module display_format import board_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic [7:0] rx_last,
	input  wire logic [7:0] press_count,
	output seg_frame_t      frame
);

	logic [7:0] rem;
	logic [3:0] hundreds;
	logic [3:0] tens;
	seg_frame_t frame_d;

	// at most two hundreds and nine tens come off
	always_comb begin
		rem      = press_count;
		hundreds = '0;
		tens     = '0;
		for (int i = 0; i < 2; i++) begin
			if (rem >= 8'd100) begin
				rem      = rem - 8'd100;
				hundreds = hundreds + 4'd1;
			end
		end
		for (int i = 0; i < 9; i++) begin
			if (rem >= 8'd10) begin
				rem  = rem - 8'd10;
				tens = tens + 4'd1;
			end
		end
	end

	always_comb begin
		for (int d = 0; d < `NUM_DIGITS; d++) begin
			frame_d[d].blank = 1'b1; // unused positions stay dark
			frame_d[d].code  = DIG_0;
		end
		frame_d[7].blank = 1'b0;
		frame_d[7].code  = digit_code_e'(rx_last[7:4]);
		frame_d[6].blank = 1'b0;
		frame_d[6].code  = digit_code_e'(rx_last[3:0]);

		// leading zeros of the count are blanked
		frame_d[2].blank = (hundreds == 4'd0);
		frame_d[2].code  = digit_code_e'(hundreds);
		frame_d[1].blank = (hundreds == 4'd0) && (tens == 4'd0);
		frame_d[1].code  = digit_code_e'(tens);
		frame_d[0].blank = 1'b0;
		frame_d[0].code  = digit_code_e'(rem[3:0]); // remainder is the ones
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame <= '1; // every digit blank
		end else begin
			frame <= frame_d;
		end
	end

endmodule

`default_nettype wire

//--- design/seg_display.sv
/*
 * seven segment scanner
 * cycles through the digits and decodes the lit one, all outputs active low
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module seg_display import board_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire seg_frame_t frame,
	output logic      [7:0] seg_number,
	output logic      [7:0] seg_choice
);

	localparam int SCAN_W  = $clog2(`SCAN_CYCLES);
	localparam int DIGIT_W = $clog2(`NUM_DIGITS);

	logic [SCAN_W-1:0]  scan_cnt;
	logic [DIGIT_W-1:0] digit_idx;
	seg_digit_t         cur;

	// gfedcba, active high here
	function automatic logic [6:0] seg_pattern(input digit_code_e code);
		case (code)
			DIG_0:   return 7'h3f;
			DIG_1:   return 7'h06;
			DIG_2:   return 7'h5b;
			DIG_3:   return 7'h4f;
			DIG_4:   return 7'h66;
			DIG_5:   return 7'h6d;
			DIG_6:   return 7'h7d;
			DIG_7:   return 7'h07;
			DIG_8:   return 7'h7f;
			DIG_9:   return 7'h6f;
			DIG_A:   return 7'h77;
			DIG_B:   return 7'h7c;
			DIG_C:   return 7'h39;
			DIG_D:   return 7'h5e;
			DIG_E:   return 7'h79;
			default: return 7'h71; // F
		endcase
	endfunction

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt  <= '0;
			digit_idx <= '0;
		end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
			scan_cnt  <= '0;
			digit_idx <= digit_idx + 1'b1; // wraps 7 -> 0
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign cur = frame[digit_idx];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= '1; // nothing lit
			seg_number <= '1;
		end else begin
			seg_choice <= ~(8'd1 << digit_idx);
			if (cur.blank) begin
				seg_number <= '1;
			end else begin
				seg_number <= {1'b1, ~seg_pattern(cur.code)}; // dp off
			end
		end
	end

	a_one_digit_lit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		1'b1 |=> $onehot(~seg_choice));

endmodule

`default_nettype wire

//--- design/buzzer.sv
/*
 * buzzer beep timer, restarted by every trigger
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module buzzer (
	input  wire logic sys_clk,
	input  wire logic sys_rst_n,
	input  wire logic trigger,
	output logic      bepeer
);

	localparam int BEEP_W = $clog2(`BEEP_CYCLES + 1);

	logic [BEEP_W-1:0] beep_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_cnt <= '0;
		end else if (trigger) begin
			beep_cnt <= BEEP_W'(`BEEP_CYCLES); // restart even mid beep
		end else if (beep_cnt != '0) begin
			beep_cnt <= beep_cnt - 1'b1;
		end
	end

	assign bepeer = (beep_cnt != '0);

endmodule

`default_nettype wire

//--- design/board_top.sv
/*
 * board subsystem top
 * keys, buzzer, spi slave and seven segment display, plus the press
 * counter and last spi byte shared between them
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module board_top import board_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic [3:0] key_in,
	output logic            bepeer,
	output logic      [7:0] led,
	output logic      [7:0] seg_number,
	output logic      [7:0] seg_choice,
	input  wire logic       cs,
	input  wire logic       sclk,
	input  wire logic       mosi,
	output logic            miso
);

	key_event_t keys;
	spi_rx_t    rx;
	seg_frame_t frame;
	logic [7:0] rx_last;
	logic [7:0] press_count;
	logic [2:0] press_inc;
	logic [8:0] count_sum;

	// several keys may hit in the same cycle
	always_comb begin
		press_inc = '0;
		for (int i = 0; i < `NUM_KEYS; i++) begin
			press_inc = press_inc + 3'(keys.press[i]);
		end
		count_sum = {1'b0, press_count} + 9'(press_inc);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			press_count <= '0;
			rx_last     <= '0; // first reply is just the offset
		end else begin
			press_count <= count_sum[8] ? 8'hff : count_sum[7:0]; // saturate
			if (rx.done) begin
				rx_last <= rx.data;
			end
		end
	end

	key_debounce u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.keys      (keys),
		.led       (led)
	);

	spi_slave #(
		.CPOL (1'b1),
		.CPHA (1'b1)
	) u_spi_slave (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.data_tx   (rx_last + `SPI_REPLY_OFFSET),
		.rx        (rx)
	);

	display_format u_display_format (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_last     (rx_last),
		.press_count (press_count),
		.frame       (frame)
	);

	seg_display u_seg_display (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frame      (frame),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	buzzer u_buzzer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.trigger   (|keys.press),
		.bepeer    (bepeer)
	);

endmodule

`default_nettype wire

//--- sim/board_tb.sv
/*
 * testbench for the board subsystem
 * random spi traffic and bouncy key presses from an lcg, with models of
 * the reply byte, press counter, leds, buzzer and display scan
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module board_tb;

	localparam int N_SPI    = 30;
	localparam int N_PRESS  = 12;
	localparam int N_BURST  = 105; // pushes the count past 100
	localparam int N_OPS    = N_SPI + N_PRESS + N_BURST + 3;
	localparam int TIMEOUT  = N_OPS * 200 + 1000;
	localparam int SPI_HALF = 5;
	localparam int SETTLE   = `DEBOUNCE_CYCLES + 4;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       cs;
	logic       sclk;
	logic       mosi;
	wire        bepeer;
	wire  [7:0] led;
	wire  [7:0] seg_number;
	wire  [7:0] seg_choice;
	wire        miso;

	logic [31:0] rng_state;
	int          mismatch_count;
	int          other_count;
	int          model_count;
	logic [3:0]  model_leds; // expected led[7:4]
	logic [7:0]  model_rx_last;

	board_top u_dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.bepeer     (bepeer),
		.led        (led),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso)
	);

	always #2 sys_clk = ~sys_clk;

	function automatic int unsigned next_rand(input int unsigned range);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 16) % range;
	endfunction

	// gfedcba, 1 = segment on
	function automatic logic [6:0] hex_segments(input int value);
		case (value)
			0: return 7'b0111111;
			1: return 7'b0000110;
			2: return 7'b1011011;
			3: return 7'b1001111;
			4: return 7'b1100110;
			5: return 7'b1101101;
			6: return 7'b1111101;
			7: return 7'b0000111;
			8: return 7'b1111111;
			9: return 7'b1101111;
			10: return 7'b1110111;
			11: return 7'b1111100;
			12: return 7'b0111001;
			13: return 7'b1011110;
			14: return 7'b1111001;
			default: return 7'b1110001;
		endcase
	endfunction

	// active low pattern for one digit position, dp always off
	function automatic logic [7:0] expected_segments(input int digit);
		int hundreds;
		int tens;
		int ones;
		hundreds = model_count / 100;
		tens     = (model_count / 10) % 10;
		ones     = model_count % 10;
		case (digit)
			7: return {1'b1, ~hex_segments(model_rx_last[7:4])};
			6: return {1'b1, ~hex_segments(model_rx_last[3:0])};
			2: return (hundreds == 0) ? 8'hff : {1'b1, ~hex_segments(hundreds)};
			1: return (hundreds == 0 && tens == 0) ? 8'hff : {1'b1, ~hex_segments(tens)};
			0: return {1'b1, ~hex_segments(ones)};
			default: return 8'hff;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		mismatch_count++;
		$display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		other_count++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// mode 3 master, shifts on falling sclk and samples miso before the rise
	task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] rx_byte);
		bit got_done;
		got_done = 1'b0;
		rx_byte  = '0;
		@(posedge sys_clk);
		cs <= 1'b0;
		wait_cycles(SPI_HALF);
		for (int i = 7; i >= 0; i--) begin
			sclk <= 1'b0;
			mosi <= tx[i];
			wait_cycles(SPI_HALF - 1);
			@(negedge sys_clk);
			rx_byte[i] = miso;
			@(posedge sys_clk);
			sclk <= 1'b1;
			for (int n = 0; n < SPI_HALF; n++) begin
				@(negedge sys_clk);
				if (i == 0 && u_dut.rx.done === 1'b1) got_done = 1'b1;
				@(posedge sys_clk);
			end
		end
		cs   <= 1'b1;
		mosi <= 1'b0;
		wait_cycles(2 * SPI_HALF);
		if (!got_done) report_failure("spi done pulse missing after a full byte");
	endtask

	// short chatter around the new level, then a stable drive
	task automatic drive_bounce(input int k, input bit pressed);
		int toggles;
		toggles = next_rand(6);
		@(posedge sys_clk);
		for (int j = 0; j < toggles; j++) begin
			key_in[k] <= (j % 2 == 0) ? ~pressed : pressed; // key is active low
			wait_cycles(1 + next_rand(8));
		end
		key_in[k] <= ~pressed;
	endtask

	task automatic press_key(input int k);
		bit seen;
		int high_cycles;
		seen        = 1'b0;
		high_cycles = 0;
		drive_bounce(k, 1'b1);
		for (int n = 0; n < SETTLE && !seen; n++) begin
			@(negedge sys_clk);
			seen = (bepeer === 1'b1);
		end
		model_count   = (model_count < 255) ? model_count + 1 : 255;
		model_leds[k] = ~model_leds[k];
		if (!seen) begin
			report_failure("bepeer did not rise after a key press");
		end else begin
			while (bepeer === 1'b1 && high_cycles < `BEEP_CYCLES + 8) begin
				high_cycles++;
				@(negedge sys_clk);
			end
			if (high_cycles != `BEEP_CYCLES) report_mismatch("beep length", `BEEP_CYCLES,
				high_cycles);
		end
		if (led !== {model_leds, 4'(1 << k)}) report_mismatch("led", {model_leds, 4'(1 << k)},
			led);
	endtask

	task automatic release_key(input int k);
		drive_bounce(k, 1'b0);
		wait_cycles(SETTLE);
		@(negedge sys_clk);
		if (led !== {model_leds, 4'b0}) report_mismatch("led", {model_leds, 4'b0}, led);
	endtask

	// clean press and release, no beep check
	task automatic tap_key(input int k);
		@(posedge sys_clk);
		key_in[k] <= 1'b0;
		wait_cycles(SETTLE);
		key_in[k] <= 1'b1;
		wait_cycles(SETTLE);
		model_count   = (model_count < 255) ? model_count + 1 : 255;
		model_leds[k] = ~model_leds[k];
	endtask

	task automatic check_scan();
		int digit;
		wait_cycles(4); // frame and scanner registers settle
		for (int n = 0; n < `NUM_DIGITS * `SCAN_CYCLES; n++) begin
			@(negedge sys_clk);
			if (!$onehot(~seg_choice)) begin
				report_failure("seg_choice does not select exactly one digit");
			end else begin
				digit = 0;
				for (int d = 0; d < `NUM_DIGITS; d++) begin
					if (seg_choice[d] == 1'b0) digit = d;
				end
				if (seg_number !== expected_segments(digit)) begin
					report_mismatch($sformatf("seg_number digit %0d", digit),
						expected_segments(digit), seg_number);
				end
			end
		end
	endtask

	initial begin
		repeat (TIMEOUT) @(posedge sys_clk);
		$display("timeout: the tests did not finish in %0d cycles", TIMEOUT);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [7:0] tx;
		logic [7:0] reply;
		int         k;
		sys_clk        = 1'b0;
		sys_rst_n      = 1'b0;
		key_in         = 4'hf; // released
		cs             = 1'b1;
		sclk           = 1'b1; // mode 3 idles high
		mosi           = 1'b0;
		rng_state      = 32'hefe4_a78e;
		mismatch_count = 0;
		other_count    = 0;
		model_count    = 0;
		model_leds     = '0;
		model_rx_last  = '0;

		repeat (15) @(posedge sys_clk);
		@(negedge sys_clk);
		if (bepeer !== 1'b0) report_mismatch("bepeer", 0, bepeer);
		if (led !== 8'h00) report_mismatch("led", 8'h00, led);
		if (seg_choice !== 8'hff) report_mismatch("seg_choice", 8'hff, seg_choice);
		@(posedge sys_clk);
		sys_rst_n <= 1'b1;
		wait_cycles(4);

		for (int t = 0; t < N_SPI; t++) begin
			tx = 8'(next_rand(256));
			spi_transfer(tx, reply);
			if (reply !== 8'(model_rx_last + `SPI_REPLY_OFFSET)) begin
				report_mismatch("miso reply", 8'(model_rx_last + `SPI_REPLY_OFFSET), reply);
			end
			model_rx_last = tx;
		end
		check_scan();

		for (int p = 0; p < N_PRESS; p++) begin
			k = next_rand(`NUM_KEYS);
			press_key(k);
			release_key(k);
		end
		check_scan();

		for (int b = 0; b < N_BURST; b++) begin
			tap_key(b % `NUM_KEYS);
		end
		@(negedge sys_clk);
		if (led !== {model_leds, 4'b0}) report_mismatch("led", {model_leds, 4'b0}, led);
		check_scan();

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/board_pkg.sv
design/key_debounce.sv
design/spi_slave.sv
design/display_format.sv
design/seg_display.sv
design/buzzer.sv
design/board_top.sv
sim/board_tb.sv

//--- Bender.yml
package:
  name: board_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/board_pkg.sv
      - design/key_debounce.sv
      - design/spi_slave.sv
      - design/display_format.sv
      - design/seg_display.sv
      - design/buzzer.sv
      - design/board_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/board_tb.sv
